/* edge_pkg.sv */
package edge_pkg;

    // one gradient magnitude sample, unsigned
    typedef logic [7:0] pixel_t;

    // suppression direction picked from the largest opposite-neighbor sum
    // order here is also the tie priority
    typedef enum logic [1:0] {
        // north+south strongest, compare against west/east
        dir_ns = 2'd0,
        // east+west strongest, compare against north/south
        dir_ew = 2'd1,
        // northwest+southeast strongest, compare against ne/sw
        dir_nw = 2'd2,
        // northeast+southwest strongest, compare against nw/se
        dir_ne = 2'd3
    } nms_dir_t;

    // filter control states
    typedef enum logic [1:0] {
        // filling the line buffer before the first window
        st_prime   = 2'd0,
        // one shift per visit, result registered on the way out
        st_advance = 2'd1,
        // result waits here until the output fifo takes it
        st_emit    = 2'd2
    } nms_state_t;

endpackage

/* fifo_if.sv */
`timescale 1ns/10ps

interface fifo_if;

    import edge_pkg::*;

    // write side
    logic   wr_en;
    logic   full;
    pixel_t din;

    // read side, data shows ahead of rd_en
    logic   rd_en;
    logic   empty;
    pixel_t dout;

    // producer pushing into the fifo
    modport writer (output wr_en, output din, input full);

    // consumer popping from the fifo
    modport reader (output rd_en, input empty, input dout);

    // the storage itself
    modport buffer (
        input  wr_en,
        input  din,
        output full,
        input  rd_en,
        output empty,
        output dout
    );

endinterface

/* pixel_fifo.sv */
`timescale 1ns/10ps

module pixel_fifo #(
    parameter int DEPTH = 16
) (
    input  logic  clock,
    input  logic  reset,
    fifo_if.buffer port
);

    import edge_pkg::*;

    localparam int AW = $clog2(DEPTH);

    // storage
    pixel_t mem [DEPTH];

    // pointers carry an extra wrap bit above the address
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    // accepted transfers this cycle
    logic wr_go;
    logic rd_go;

    assign wr_go = port.wr_en && !port.full;
    assign rd_go = port.rd_en && !port.empty;

    // same address, same lap -> nothing held
    assign port.empty = (wr_ptr == rd_ptr);
    // same address, different lap -> every slot held
    assign port.full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // first word falls through, valid whenever empty is low
    assign port.dout = mem[rd_ptr[AW-1:0]];

    // pointer control
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_go) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_go) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // write port into the array
    always_ff @(posedge clock) begin
        if (wr_go) begin
            mem[wr_ptr[AW-1:0]] <= port.din;
        end
    end

    // the writer must hold off while every slot is taken
    assert property (@(posedge clock) disable iff (reset) port.wr_en |-> !port.full)
        else $error("pixel_fifo overflow, write requested while full");

    // the reader must hold off while nothing is held
    assert property (@(posedge clock) disable iff (reset) port.rd_en |-> !port.empty)
        else $error("pixel_fifo underflow, read requested while empty");

endmodule

/* nms_filter.sv */
`timescale 1ns/10ps

module nms_filter #(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 6
) (
    input  logic  clock,
    input  logic  reset,
    fifo_if.reader src,
    fifo_if.writer dst
);

    import edge_pkg::*;

    // two full lines plus three pixels cover a 3x3 window
    localparam int SHIFT_LEN = 2*WIDTH + 3;
    localparam int PIXELS    = WIDTH*HEIGHT;
    localparam int CNT_W     = $clog2(PIXELS + 1);
    localparam int COL_W     = $clog2(WIDTH);
    localparam int ROW_W     = $clog2(HEIGHT);

    nms_state_t state;
    nms_state_t state_next;

    // line buffer, oldest pixel at index 0
    pixel_t shift_reg  [SHIFT_LEN];
    pixel_t shift_next [SHIFT_LEN];
    logic   do_shift;
    pixel_t shift_in;

    // pixels taken from the input this frame
    logic [CNT_W-1:0] read_cnt;
    // position of the window center
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;

    // suppressed value waiting for the output fifo
    pixel_t result;

    logic padding;
    logic last_pixel;
    logic on_border;

    // window taps, taken after this cycle's shift
    pixel_t nw_px, n_px, ne_px;
    pixel_t w_px,  c_px, e_px;
    pixel_t sw_px, s_px, se_px;

    // opposite-neighbor sums, 9 bits so nothing wraps
    logic [8:0] sum_ns;
    logic [8:0] sum_ew;
    logic [8:0] sum_nw;
    logic [8:0] sum_ne;

    nms_dir_t dir;
    logic     keep;

    // every real pixel read, bottom padding from here on
    assign padding    = (read_cnt == CNT_W'(PIXELS));
    assign last_pixel = (row == ROW_W'(HEIGHT-1)) && (col == COL_W'(WIDTH-1));
    assign on_border  = (row == '0) || (row == ROW_W'(HEIGHT-1))
                     || (col == '0) || (col == COL_W'(WIDTH-1));

    // control fsm
    always_comb begin
        state_next = state;
        src.rd_en  = 1'b0;
        dst.wr_en  = 1'b0;
        do_shift   = 1'b0;
        shift_in   = src.dout;
        case (state)
            st_prime: begin
                // fill up to one pixel short of the first center
                if (!src.empty) begin
                    do_shift  = 1'b1;
                    src.rd_en = 1'b1;
                    if (read_cnt == CNT_W'(WIDTH)) begin
                        state_next = st_advance;
                    end
                end
            end
            st_advance: begin
                if (padding) begin
                    // zeros past the end of the frame
                    do_shift   = 1'b1;
                    shift_in   = '0;
                    state_next = st_emit;
                end else if (!src.empty) begin
                    do_shift   = 1'b1;
                    src.rd_en  = 1'b1;
                    state_next = st_emit;
                end
            end
            st_emit: begin
                // hold here under back-pressure
                if (!dst.full) begin
                    dst.wr_en  = 1'b1;
                    state_next = last_pixel ? st_prime : st_advance;
                end
            end
            default: begin
                state_next = st_prime;
            end
        endcase
    end

    assign dst.din = result;

    // shift right by one, new pixel enters at the top
    always_comb begin
        shift_next = shift_reg;
        if (do_shift) begin
            for (int i = 0; i < SHIFT_LEN-1; i++) begin
                shift_next[i] = shift_reg[i+1];
            end
            shift_next[SHIFT_LEN-1] = shift_in;
        end
    end

    // rows of the window sit WIDTH apart
    assign nw_px = shift_next[0];
    assign n_px  = shift_next[1];
    assign ne_px = shift_next[2];
    assign w_px  = shift_next[WIDTH];
    assign c_px  = shift_next[WIDTH+1];
    assign e_px  = shift_next[WIDTH+2];
    assign sw_px = shift_next[2*WIDTH];
    assign s_px  = shift_next[2*WIDTH+1];
    assign se_px = shift_next[2*WIDTH+2];

    assign sum_ns = {1'b0, n_px}  + {1'b0, s_px};
    assign sum_ew = {1'b0, w_px}  + {1'b0, e_px};
    assign sum_nw = {1'b0, nw_px} + {1'b0, se_px};
    assign sum_ne = {1'b0, ne_px} + {1'b0, sw_px};

    // largest sum wins, ties go to the earlier direction
    always_comb begin
        if (sum_ns >= sum_ew && sum_ns >= sum_nw && sum_ns >= sum_ne) begin
            dir = dir_ns;
        end else if (sum_ew >= sum_nw && sum_ew >= sum_ne) begin
            dir = dir_ew;
        end else if (sum_nw >= sum_ne) begin
            dir = dir_nw;
        end else begin
            dir = dir_ne;
        end
    end

    // center must beat the pair across the chosen direction
    always_comb begin
        case (dir)
            dir_ns:  keep = (c_px > w_px)  && (c_px >= e_px);
            dir_ew:  keep = (c_px > n_px)  && (c_px >= s_px);
            dir_nw:  keep = (c_px > ne_px) && (c_px >= sw_px);
            default: keep = (c_px > nw_px) && (c_px >= se_px);
        endcase
    end

    // state and counters
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= st_prime;
            read_cnt <= '0;
            col      <= '0;
            row      <= '0;
        end else begin
            state <= state_next;
            if (src.rd_en) begin
                read_cnt <= read_cnt + 1'b1;
            end
            // center moves on once its result has left
            if (dst.wr_en) begin
                if (last_pixel) begin
                    read_cnt <= '0;
                    col      <= '0;
                    row      <= '0;
                end else if (col == COL_W'(WIDTH-1)) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // line buffer and result
    always_ff @(posedge clock) begin
        shift_reg <= shift_next;
        if (state == st_advance && do_shift) begin
            result <= (!on_border && keep) ? c_px : '0;
        end
    end

    // input fifo must not see a pop while it is empty
    assert property (@(posedge clock) disable iff (reset) src.rd_en |-> !src.empty)
        else $error("nms_filter read while input empty");

    // output fifo must not see a push while it is full
    assert property (@(posedge clock) disable iff (reset) dst.wr_en |-> !dst.full)
        else $error("nms_filter write while output full");

    assert property (@(posedge clock) disable iff (reset)
        state inside {st_prime, st_advance, st_emit})
        else $error("nms_filter illegal state %0d", state);

endmodule

/* edge_thin_top.sv */
`timescale 1ns/10ps

module edge_thin_top #(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 6,
    parameter int DEPTH  = 16
) (
    input  logic            clock,
    input  logic            reset,
    // pixel stream in, raster order
    input  logic            in_wr_en,
    input  edge_pkg::pixel_t in_din,
    output logic            in_full,
    // thinned stream out, same order
    input  logic            out_rd_en,
    output edge_pkg::pixel_t out_dout,
    output logic            out_empty
);

    // gradient pixels into the filter
    fifo_if in_link ();
    // suppressed pixels out of the filter
    fifo_if out_link ();

    // input fifo write side comes straight from the pins
    assign in_link.wr_en = in_wr_en;
    assign in_link.din   = in_din;
    assign in_full       = in_link.full;

    // output fifo read side goes straight to the pins
    assign out_link.rd_en = out_rd_en;
    assign out_dout       = out_link.dout;
    assign out_empty      = out_link.empty;

    pixel_fifo #(
        .DEPTH (DEPTH)
    ) in_fifo (
        .clock (clock),
        .reset (reset),
        .port  (in_link.buffer)
    );

    nms_filter #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) nms_core (
        .clock (clock),
        .reset (reset),
        .src   (in_link.reader),
        .dst   (out_link.writer)
    );

    pixel_fifo #(
        .DEPTH (DEPTH)
    ) out_fifo (
        .clock (clock),
        .reset (reset),
        .port  (out_link.buffer)
    );

endmodule

/* tb_nms_model.svh */
`ifndef TB_NMS_MODEL_SVH
`define TB_NMS_MODEL_SVH

// image kinds for make_image
localparam int IMG_CONST    = 0;
localparam int IMG_RANDOM   = 1;
localparam int IMG_VLINE    = 2;
localparam int IMG_HLINE    = 3;
localparam int IMG_DIAG     = 4;
localparam int IMG_ANTIDIAG = 5;

// galois lfsr, shifts right, taps 32 30 26 25
logic [31:0] lfsr_state = 32'd98539;

// current test image, row major
pixel_t img [HEIGHT][WIDTH];

function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
        lfsr_state = lfsr_state ^ 32'hA300_0000;
    end
    return b;
endfunction

// one lfsr step per bit
function automatic pixel_t lfsr_byte();
    pixel_t v;
    v = '0;
    for (int i = 0; i < 8; i++) begin
        v = {v[6:0], lfsr_bit()};
    end
    return v;
endfunction

// ridges sit at 200 on a flat background of 10
task automatic make_image(input int kind);
    for (int r = 0; r < HEIGHT; r++) begin
        for (int c = 0; c < WIDTH; c++) begin
            case (kind)
                IMG_CONST:    img[r][c] = 8'd90;
                IMG_RANDOM:   img[r][c] = lfsr_byte();
                IMG_VLINE:    img[r][c] = (c == 3) ? 8'd200 : 8'd10;
                IMG_HLINE:    img[r][c] = (r == 2) ? 8'd200 : 8'd10;
                IMG_DIAG:     img[r][c] = (r == c) ? 8'd200 : 8'd10;
                default:      img[r][c] = (r + c == 6) ? 8'd200 : 8'd10;
            endcase
        end
    end
endtask

function automatic int pixel_at(input int r, input int c);
    return int'(img[r][c]);
endfunction

// expected output for one pixel of img
function automatic pixel_t suppress_ref(input int r, input int c);
    int ns;
    int ew;
    int nwse;
    int nesw;
    int best;
    int cv;
    nms_dir_t d;
    logic pass;
    if (r == 0 || r == HEIGHT-1 || c == 0 || c == WIDTH-1) begin
        return 8'd0;
    end
    cv   = pixel_at(r, c);
    ns   = pixel_at(r-1, c) + pixel_at(r+1, c);
    ew   = pixel_at(r, c-1) + pixel_at(r, c+1);
    nwse = pixel_at(r-1, c-1) + pixel_at(r+1, c+1);
    nesw = pixel_at(r-1, c+1) + pixel_at(r+1, c-1);
    best = ns;
    best = (ew > best) ? ew : best;
    best = (nwse > best) ? nwse : best;
    best = (nesw > best) ? nesw : best;
    // first direction reaching the maximum wins
    if (ns == best) d = dir_ns;
    else if (ew == best) d = dir_ew;
    else if (nwse == best) d = dir_nw;
    else d = dir_ne;
    case (d)
        dir_ns:  pass = cv > pixel_at(r, c-1) && cv >= pixel_at(r, c+1);
        dir_ew:  pass = cv > pixel_at(r-1, c) && cv >= pixel_at(r+1, c);
        dir_nw:  pass = cv > pixel_at(r-1, c+1) && cv >= pixel_at(r+1, c-1);
        default: pass = cv > pixel_at(r-1, c-1) && cv >= pixel_at(r+1, c+1);
    endcase
    return pass ? img[r][c] : 8'd0;
endfunction

`endif

/* tb_edge_thin.sv */
`timescale 1ns/10ps

module tb_edge_thin;

    import edge_pkg::*;

    localparam int WIDTH  = 8;
    localparam int HEIGHT = 6;
    localparam int DEPTH  = 16;
    // frames over all tests, sets the timeout
    localparam int FRAMES      = 9;
    localparam int CYCLE_LIMIT = 4*FRAMES*WIDTH*HEIGHT*2 + 400;

    logic   clock;
    logic   reset;
    logic   in_wr_en;
    pixel_t in_din;
    logic   in_full;
    logic   out_rd_en;
    pixel_t out_dout;
    logic   out_empty;

    // pixels to send and bytes to expect, in stream order
    pixel_t push_q [$];
    pixel_t expect_q [$];
    int     received;
    int     checks;
    int     errors;
    int     cycles;

    `include "tb_nms_model.svh"

    edge_thin_top #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT),
        .DEPTH  (DEPTH)
    ) edge_thin_top_i (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    always #10 clock = ~clock;

    // run limit
    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d output bytes arrived",
                     cycles, received, expect_q.size());
            $display("checks %0d, errors %0d", checks, errors + 1);
            $display("sim failed");
            $finish;
        end
    end

    task automatic compare_byte(input pixel_t got, input pixel_t exp, input int idx);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("FAIL %0t out_dout byte %0d got %0d expected %0d", $time, idx, got, exp);
        end
    endtask

    // image plus its model output onto the queues
    task automatic queue_frame(input int kind);
        make_image(kind);
        for (int r = 0; r < HEIGHT; r++) begin
            for (int c = 0; c < WIDTH; c++) begin
                push_q.push_back(img[r][c]);
                expect_q.push_back(suppress_ref(r, c));
            end
        end
    endtask

    // feed and drain concurrently, optional idle gaps and held-off reads
    task automatic stream_frames(input bit gaps, input bit stall);
        int n;
        int sent;
        n = push_q.size();
        sent = 0;
        received = 0;
        fork
            begin
                while (sent < n) begin
                    @(negedge clock);
                    if (!in_full && !(gaps && lfsr_bit())) begin
                        in_wr_en = 1'b1;
                        in_din   = push_q[sent];
                        sent++;
                    end else begin
                        in_wr_en = 1'b0;
                    end
                end
                @(negedge clock);
                in_wr_en = 1'b0;
            end
            begin
                // reads start only once the pipe has backed up to the input
                while (stall && !in_full) begin
                    @(negedge clock);
                end
                while (received < n) begin
                    @(negedge clock);
                    if (!out_empty) begin
                        out_rd_en = 1'b1;
                        compare_byte(out_dout, expect_q[received], received);
                        received++;
                    end else begin
                        out_rd_en = 1'b0;
                    end
                end
                @(negedge clock);
                out_rd_en = 1'b0;
            end
        join
        // nothing more may come out
        repeat (4*WIDTH) @(negedge clock);
        assert (out_empty)
        else begin
            errors++;
            $display("extra output byte appeared after the frame at %0t", $time);
        end
        push_q.delete();
        expect_q.delete();
    endtask

    task automatic reset_state_check();
        assert (out_empty === 1'b1)
        else begin
            errors++;
            $display("FAIL %0t out_empty got %b expected 1", $time, out_empty);
        end
        assert (in_full === 1'b0)
        else begin
            errors++;
            $display("FAIL %0t in_full got %b expected 0", $time, in_full);
        end
    endtask

    task automatic constant_frame();
        queue_frame(IMG_CONST);
        stream_frames(1'b0, 1'b0);
    endtask

    task automatic random_frame();
        queue_frame(IMG_RANDOM);
        stream_frames(1'b0, 1'b0);
    endtask

    // one ridge per direction branch
    task automatic ridge_frames();
        queue_frame(IMG_VLINE);
        stream_frames(1'b0, 1'b0);
        queue_frame(IMG_HLINE);
        stream_frames(1'b0, 1'b0);
        queue_frame(IMG_DIAG);
        stream_frames(1'b0, 1'b0);
        queue_frame(IMG_ANTIDIAG);
        stream_frames(1'b0, 1'b0);
    endtask

    task automatic output_backpressure();
        queue_frame(IMG_RANDOM);
        stream_frames(1'b0, 1'b1);
    endtask

    // second frame follows with no reset in between
    task automatic input_gaps_back_to_back();
        queue_frame(IMG_RANDOM);
        queue_frame(IMG_RANDOM);
        stream_frames(1'b1, 1'b0);
    endtask

    initial begin
        clock     = 1'b0;
        reset     = 1'b1;
        in_wr_en  = 1'b0;
        in_din    = '0;
        out_rd_en = 1'b0;
        checks    = 0;
        errors    = 0;
        cycles    = 0;
        received  = 0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        reset_state_check();
        constant_frame();
        random_frame();
        ridge_frames();
        output_backpressure();
        input_gaps_back_to_back();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
edge_pkg.sv
fifo_if.sv
pixel_fifo.sv
nms_filter.sv
edge_thin_top.sv
tb_edge_thin.sv

/* Makefile */
# Verilator build and run for the edge thinning testbench

VERILATOR ?= verilator
TOP       ?= tb_edge_thin
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
HEADERS   ?= tb_nms_model.svh
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "sim failed" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
